/* design/gamePkg.sv */
package gamePkg;

    // --------------------
    // Frame geometry
    // --------------------

    // Visible pixels per line
    localparam int cHdisplay = 16;
    // Visible lines per frame
    localparam int cVdisplay = 12;
    // Width of scan counters and sprite position
    localparam int cPosWidth = 4;

    // --------------------
    // Pixel format and colours
    // --------------------

    // Packed RGB, 8 bits per channel
    localparam int cPixelWidth = 24;

    // Sprite edge in pixels
    localparam int cSpriteSize = 4;

    // Sprite palette A and B
    localparam logic [cPixelWidth-1:0] cSpriteColorA = 24'hF0C020;
    localparam logic [cPixelWidth-1:0] cSpriteColorB = 24'h20C0F0;

    // Checkerboard tones
    localparam logic [cPixelWidth-1:0] cBgColorA = 24'h202040;
    localparam logic [cPixelWidth-1:0] cBgColorB = 24'h404080;

    // --------------------
    // Buffering and control
    // --------------------

    // Pixel buffer entries, power of two
    localparam int cBuffDepth = 32;

    // Frame sequencer states
    typedef enum logic [1:0] {
        cIdle,
        cRun,
        cUpdate
    } frameStateT;

endpackage

/* design/frameControl.sv */
`timescale 1ns/10ps

module frameControl (
    input  logic iBCLK,
    input  logic iRST,
    input  logic frameEnd,
    input  logic full,
    output logic cke,
    output logic update,
    output logic oFrameSync
);

    import gamePkg::*;

    frameStateT state;

    // --------------------
    // Sequencer
    // --------------------

    // Idle for one cycle after reset, then scan
    // One update cycle after the last pixel of every frame
    always_ff @(posedge iBCLK)
    begin
        if (iRST)
        begin
            state <= cIdle;
        end
        else
        begin
            case (state)
                cIdle:
                begin
                    state <= cRun;
                end
                cRun:
                begin
                    // Last pixel actually written this cycle
                    if (cke && frameEnd)
                    begin
                        state <= cUpdate;
                    end
                end
                cUpdate:
                begin
                    state <= cRun;
                end
                default:
                begin
                    state <= cIdle;
                end
            endcase
        end
    end

    // --------------------
    // Outputs
    // --------------------

    // Scan only while the buffer has room
    assign cke = (state == cRun) && !full;

    // Position step, also exported as frame sync
    assign update     = (state == cUpdate);
    assign oFrameSync = update;

    // Scan stopped during update, entered only from a written last pixel
    assert property (@(posedge iBCLK) disable iff (iRST)
        update |-> !cke && $past(cke && frameEnd));

    // Update step is a single cycle
    assert property (@(posedge iBCLK) disable iff (iRST)
        update |=> !update);

endmodule

/* design/positionGen.sv */
`timescale 1ns/10ps

module positionGen (
    input  logic                          iBCLK,
    input  logic                          iRST,
    input  logic [5:0]                    iBtn,
    input  logic                          update,
    output logic [gamePkg::cPosWidth-1:0] posX,
    output logic [gamePkg::cPosWidth-1:0] posY,
    output logic                          paletteSel,
    output logic [7:0]                    oLed
);

    import gamePkg::*;

    // Two-flop synchronizer stages
    logic [5:0] btnMeta;
    logic [5:0] btnSync;

    // One step towards inc or dec, held at 0 and posMax
    // Both directions at once cancel
    function automatic logic [cPosWidth-1:0] stepPos(
        input logic [cPosWidth-1:0] pos,
        input logic                 dec,
        input logic                 inc,
        input int unsigned          posMax
    );
        logic [cPosWidth-1:0] result;
        result = pos;
        if (inc && !dec && pos < posMax)
        begin
            result = pos + 1'b1;
        end
        else if (dec && !inc && pos != '0)
        begin
            result = pos - 1'b1;
        end
        return result;
    endfunction

    // --------------------
    // Button sync and LEDs
    // --------------------

    always_ff @(posedge iBCLK)
    begin
        if (iRST)
        begin
            btnMeta <= '0;
            btnSync <= '0;
            oLed    <= '0;
        end
        else
        begin
            btnMeta <= iBtn;
            btnSync <= btnMeta;
            // Mirror, upper LEDs unused
            oLed    <= {2'b00, btnSync};
        end
    end

    // --------------------
    // Sprite position
    // --------------------

    // Btn 0 up, 1 down, 2 left, 3 right, 4 centre, 5 palette
    always_ff @(posedge iBCLK)
    begin
        if (iRST)
        begin
            posX       <= '0;
            posY       <= '0;
            paletteSel <= 1'b0;
        end
        else if (update)
        begin
            if (btnSync[4])
            begin
                // Centre of the frame, sprite corner at 6, 4
                posX <= cPosWidth'((cHdisplay - cSpriteSize) / 2);
                posY <= cPosWidth'((cVdisplay - cSpriteSize) / 2);
            end
            else
            begin
                posX <= stepPos(posX, btnSync[2], btnSync[3], cHdisplay - cSpriteSize);
                posY <= stepPos(posY, btnSync[0], btnSync[1], cVdisplay - cSpriteSize);
            end
            if (btnSync[5])
            begin
                paletteSel <= !paletteSel;
            end
        end
    end

    // Sprite stays fully on screen
    assert property (@(posedge iBCLK) disable iff (iRST)
        posX <= cHdisplay - cSpriteSize && posY <= cVdisplay - cSpriteSize);

endmodule

/* design/dotGen.sv */
`timescale 1ns/10ps

module dotGen (
    input  logic                            iBCLK,
    input  logic                            iRST,
    input  logic                            cke,
    input  logic [gamePkg::cPosWidth-1:0]   posX,
    input  logic [gamePkg::cPosWidth-1:0]   posY,
    input  logic                            paletteSel,
    output logic [gamePkg::cPixelWidth-1:0] pixel,
    output logic                            frameEnd
);

    import gamePkg::*;

    // Current scan point
    logic [cPosWidth-1:0] scanX;
    logic [cPosWidth-1:0] scanY;

    // Last column and last line of the frame
    logic lastPixel;
    logic lastLine;

    // Scan point covered by the sprite
    logic inSprite;

    // --------------------
    // Raster counters
    // --------------------

    assign lastPixel = (scanX == cPosWidth'(cHdisplay - 1));
    assign lastLine  = (scanY == cPosWidth'(cVdisplay - 1));
    assign frameEnd  = lastPixel && lastLine;

    // Advance one point per written pixel
    always_ff @(posedge iBCLK)
    begin
        if (iRST)
        begin
            scanX <= '0;
            scanY <= '0;
        end
        else if (cke)
        begin
            if (lastPixel)
            begin
                scanX <= '0;
                // Wrap to the top after the last line
                if (lastLine)
                begin
                    scanY <= '0;
                end
                else
                begin
                    scanY <= scanY + 1'b1;
                end
            end
            else
            begin
                scanX <= scanX + 1'b1;
            end
        end
    end

    // --------------------
    // Colour select
    // --------------------

    // Square from posX, posY, edge cSpriteSize
    // Int compare avoids wrap at the right edge
    assign inSprite = (scanX >= posX) && (scanX < posX + cSpriteSize)
                   && (scanY >= posY) && (scanY < posY + cSpriteSize);

    always_comb
    begin
        if (inSprite)
        begin
            pixel = paletteSel ? cSpriteColorB : cSpriteColorA;
        end
        // Checker cells the size of the sprite
        else if (scanX[$clog2(cSpriteSize)] == scanY[$clog2(cSpriteSize)])
        begin
            pixel = cBgColorA;
        end
        else
        begin
            pixel = cBgColorB;
        end
    end

endmodule

/* design/pixelFifo.sv */
`timescale 1ns/10ps

module pixelFifo (
    input  logic                            iBCLK,
    input  logic                            iRST,
    input  logic [gamePkg::cPixelWidth-1:0] wrData,
    input  logic                            wrEn,
    output logic                            full,
    output logic                            oEmpty,
    input  logic                            iRe,
    output logic [gamePkg::cPixelWidth-1:0] oRgb
);

    import gamePkg::*;

    // Pixel storage
    logic [cPixelWidth-1:0] mem [cBuffDepth];

    // Pointers wrap naturally at the power-of-two depth
    logic [$clog2(cBuffDepth)-1:0] wrPtr;
    logic [$clog2(cBuffDepth)-1:0] rdPtr;
    // Occupancy, one bit wider to hold cBuffDepth
    logic [$clog2(cBuffDepth):0]   count;

    // Accepted transfers
    logic wrOk;
    logic rdOk;

    assign full   = (count == cBuffDepth);
    assign oEmpty = (count == '0);
    assign wrOk   = wrEn && !full;
    assign rdOk   = iRe && !oEmpty;

    // --------------------
    // Storage
    // --------------------

    always_ff @(posedge iBCLK)
    begin
        if (wrOk)
        begin
            mem[wrPtr] <= wrData;
        end
    end

    // --------------------
    // Pointers and count
    // --------------------

    always_ff @(posedge iBCLK)
    begin
        if (iRST)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            oRgb  <= '0;
        end
        else
        begin
            if (wrOk)
            begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (rdOk)
            begin
                rdPtr <= rdPtr + 1'b1;
                // Head pixel out one cycle after the strobe, held otherwise
                oRgb  <= mem[rdPtr];
            end
            case ({wrOk, rdOk})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Writer is throttled by full upstream
    assert property (@(posedge iBCLK) disable iff (iRST) full |-> !wrEn);

    // Refused read only when the read pointer has caught up
    assert property (@(posedge iBCLK) disable iff (iRST)
        iRe && oEmpty |-> rdPtr == wrPtr);

endmodule

/* design/gameBase.sv */
`timescale 1ns/10ps

module gameBase (
    input  logic                            iBCLK,
    input  logic                            iRST,
    input  logic [5:0]                      iBtn,
    input  logic                            iRe,
    output logic [gamePkg::cPixelWidth-1:0] oRgb,
    output logic                            oEmpty,
    output logic                            oFrameSync,
    output logic [7:0]                      oLed
);

    import gamePkg::*;

    // Control
    logic cke;
    logic update;
    logic frameEnd;
    logic full;

    // Sprite state
    logic [cPosWidth-1:0] posX;
    logic [cPosWidth-1:0] posY;
    logic                 paletteSel;

    // Generated pixel into the buffer
    logic [cPixelWidth-1:0] pixel;

    // --------------------
    // Frame sequencing
    // --------------------

    frameControl uFrameControl (
        .iBCLK      (iBCLK),
        .iRST       (iRST),
        .frameEnd   (frameEnd),
        .full       (full),
        .cke        (cke),
        .update     (update),
        .oFrameSync (oFrameSync)
    );

    // --------------------
    // Position and LEDs
    // --------------------

    positionGen uPositionGen (
        .iBCLK      (iBCLK),
        .iRST       (iRST),
        .iBtn       (iBtn),
        .update     (update),
        .posX       (posX),
        .posY       (posY),
        .paletteSel (paletteSel),
        .oLed       (oLed)
    );

    // --------------------
    // Pixel path
    // --------------------

    dotGen uDotGen (
        .iBCLK      (iBCLK),
        .iRST       (iRST),
        .cke        (cke),
        .posX       (posX),
        .posY       (posY),
        .paletteSel (paletteSel),
        .pixel      (pixel),
        .frameEnd   (frameEnd)
    );

    // Write strobe is the scan enable
    pixelFifo uPixelFifo (
        .iBCLK  (iBCLK),
        .iRST   (iRST),
        .wrData (pixel),
        .wrEn   (cke),
        .full   (full),
        .oEmpty (oEmpty),
        .iRe    (iRe),
        .oRgb   (oRgb)
    );

endmodule

/* verification/gameBaseTb.sv */
`timescale 1ns/10ps

module gameBaseTb;

    import gamePkg::*;

    // --------------------
    // Run limits
    // --------------------

    localparam int cFrames       = 44;
    localparam int cFramePix     = cHdisplay * cVdisplay;
    localparam int cSyncTimeout  = 4000;
    localparam int cEmptyTimeout = 200;
    localparam int cDoneTimeout  = 20000;
    localparam int cResetTimeout = 20;
    // Reader pause, long enough to fill the buffer
    localparam int cPauseCycles  = 400;

    logic                   iBCLK;
    logic                   iRST;
    logic [5:0]             iBtn;
    logic                   iRe;
    logic [cPixelWidth-1:0] oRgb;
    logic                   oEmpty;
    logic                   oFrameSync;
    logic [7:0]             oLed;

    // Buttons per frame, entry k applied at sync k+1
    logic [5:0] sched [cFrames];
    // Pixel indices where reading stops for a while
    int         pauseAt [3] = '{700, 2500, 6100};
    int         seed;
    bit         readerDone;

    gameBase i_dut (
        .iBCLK      (iBCLK),
        .iRST       (iRST),
        .iBtn       (iBtn),
        .iRe        (iRe),
        .oRgb       (oRgb),
        .oEmpty     (oEmpty),
        .oFrameSync (oFrameSync),
        .oLed       (oLed)
    );

    initial
    begin
        iBCLK = 1'b0;
        forever #50 iBCLK = ~iBCLK;
    end

    // --------------------
    // Helpers
    // --------------------

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation aborted");
    endtask

    task automatic compareVal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual)
        begin
            abortRun($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // Position and palette after frame updates, then colour of one point
    function automatic logic [cPixelWidth-1:0] refPixel(input int frame, input int x,
                                                        input int y);
        int         i;
        int         px;
        int         py;
        bit         pal;
        logic [5:0] b;
        px  = 0;
        py  = 0;
        pal = 1'b0;
        for (i = 0; i < frame; i++)
        begin
            b = sched[i];
            if (b[4])
            begin
                px = 6;
                py = 4;
            end
            else
            begin
                // Opposing buttons cancel out
                px = px + int'(b[3]) - int'(b[2]);
                py = py + int'(b[1]) - int'(b[0]);
                if (px < 0) px = 0;
                if (px > cHdisplay - cSpriteSize) px = cHdisplay - cSpriteSize;
                if (py < 0) py = 0;
                if (py > cVdisplay - cSpriteSize) py = cVdisplay - cSpriteSize;
            end
            if (b[5])
            begin
                pal = !pal;
            end
        end
        if (x >= px && x < px + cSpriteSize && y >= py && y < py + cSpriteSize)
        begin
            return pal ? cSpriteColorB : cSpriteColorA;
        end
        // Checker on bit 2 of x and y
        if ((x / 4) % 2 == (y / 4) % 2)
        begin
            return cBgColorA;
        end
        return cBgColorB;
    endfunction

    task automatic buildSchedule();
        int i;
        for (i = 0; i < cFrames; i++)
        begin
            if (i < 13)
                sched[i] = 6'b001010;   // right and down
            else if (i < 26)
                sched[i] = 6'b000101;   // left and up
            else
                sched[i] = 6'($random(seed));
        end
        // Recentre, palette, idle, recentre wins over right, all directions
        sched[26] = 6'b010000;
        sched[27] = 6'b100000;
        sched[28] = 6'b000000;
        sched[29] = 6'b111000;
        sched[30] = 6'b001111;
    endtask

    task automatic waitFrameSync(input int k);
        int cycles;
        cycles = 0;
        @(negedge iBCLK);
        while (!oFrameSync)
        begin
            cycles++;
            if (cycles > cSyncTimeout)
            begin
                abortRun($sformatf("Timeout waiting for frame sync %0d", k));
            end
            @(negedge iBCLK);
        end
    endtask

    // LEDs settle within five cycles of a button change
    task automatic checkLeds(input int k);
        repeat (5) @(negedge iBCLK);
        compareVal($sformatf("oLed for schedule entry %0d", k), {2'b00, sched[k]}, oLed);
    endtask

    task automatic waitReaderDone();
        int cycles;
        cycles = 0;
        while (!readerDone)
        begin
            cycles++;
            if (cycles > cDoneTimeout)
            begin
                abortRun("Timeout waiting for the reader to finish all frames");
            end
            @(negedge iBCLK);
        end
    endtask

    // --------------------
    // Reset and buttons
    // --------------------

    initial
    begin
        int k;
        seed = 32'ha541;
        iRST = 1'b1;
        // All buttons pressed through reset, the mirror must still clear
        iBtn = 6'h3f;
        buildSchedule();
        repeat (3) @(posedge iBCLK);
        @(negedge iBCLK);
        iRST = 1'b0;
        compareVal("oLed after reset", 32'd0, oLed);
        compareVal("oEmpty after reset", 32'd1, oEmpty);
        compareVal("oRgb after reset", 32'd0, oRgb);
        compareVal("oFrameSync after reset", 32'd0, oFrameSync);
        iBtn = sched[0];
        checkLeds(0);
        // Next entry goes out right after each sync
        for (k = 1; k < cFrames; k++)
        begin
            waitFrameSync(k);
            iBtn = sched[k];
            // Frame sync is a single-cycle pulse
            @(negedge iBCLK);
            compareVal($sformatf("oFrameSync width at sync %0d", k), 32'd0, oFrameSync);
            checkLeds(k);
        end
        waitReaderDone();
        $display("Test completed successfully");
        $finish;
    end

    // --------------------
    // Reader and pixel checks
    // --------------------

    initial
    begin
        int                     pixIdx;
        int                     frame;
        int                     pos;
        int                     idle;
        int                     pauseLeft;
        int                     pauseIdx;
        int                     cycles;
        bit                     pending;
        logic [cPixelWidth-1:0] expected;
        iRe        = 1'b0;
        readerDone = 1'b0;
        pixIdx     = 0;
        idle       = 0;
        pauseLeft  = 0;
        pauseIdx   = 0;
        cycles     = 0;
        pending    = 1'b0;
        @(negedge iBCLK);
        while (iRST)
        begin
            cycles++;
            if (cycles > cResetTimeout)
            begin
                abortRun("Reset was never released");
            end
            @(negedge iBCLK);
        end
        while (pixIdx < cFrames * cFramePix)
        begin
            @(negedge iBCLK);
            // Pixel from the strobe of the previous cycle
            if (pending)
            begin
                frame    = pixIdx / cFramePix;
                pos      = pixIdx % cFramePix;
                expected = refPixel(frame, pos % cHdisplay, pos / cHdisplay);
                compareVal($sformatf("pixel %0d of frame %0d", pos, frame), expected, oRgb);
                pixIdx++;
                pending = 1'b0;
            end
            if (pauseIdx < 3 && pixIdx == pauseAt[pauseIdx])
            begin
                pauseLeft = cPauseCycles;
                pauseIdx++;
            end
            if (pixIdx >= cFrames * cFramePix || pauseLeft > 0)
            begin
                iRe = 1'b0;
                if (pauseLeft > 0)
                    pauseLeft--;
            end
            else if (oEmpty)
            begin
                iRe = 1'b0;
                idle++;
                if (idle > cEmptyTimeout)
                begin
                    abortRun("Pixel buffer stayed empty, the scan has stalled");
                end
            end
            else
            begin
                // Strobe about three cycles in four
                idle    = 0;
                iRe     = (($random(seed) & 3) != 0);
                pending = iRe;
            end
        end
        iRe        = 1'b0;
        readerDone = 1'b1;
    end

endmodule

/* gameBase.f */
design/gamePkg.sv
design/frameControl.sv
design/positionGen.sv
design/dotGen.sv
design/pixelFifo.sv
design/gameBase.sv
verification/gameBaseTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the gameBase testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Test failed"

verilator --binary --timing --assert -Wno-fatal \
    --top-module gameBaseTb -f gameBase.f -o gameBaseSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/gameBaseSim > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

if [ $runStatus -ne 0 ]; then
    echo "Simulator exited with status $runStatus"
    exit 1
fi

echo "Simulation passed"
exit 0
